// File: all.f
verilog/core_pkg.sv
verilog/instruction_queue.sv
verilog/decode_issue.sv
verilog/register_file.sv
verilog/reservation_station.sv
verilog/alu.sv
verilog/rob.sv
verilog/top_level.sv
bench/top_level_tb.sv

// File: bench/top_level_tb.sv
`default_nettype none

module top_level_tb import core_pkg::*; ();

  localparam int MAX_ROWS = 64;
  localparam int BURST_LEN = 16; // twice the rob depth

  logic clk_100mhz;
  logic rst_n;
  logic [31:0] instruction;
  logic iq_valid;
  logic iq_ready;
  logic commit;
  logic [4:0] commit_dest;
  logic [31:0] commit_value;

  // program table
  string row_name [MAX_ROWS];
  logic [31:0] row_word [MAX_ROWS];
  logic [4:0] row_dest [MAX_ROWS];
  logic [31:0] row_value [MAX_ROWS];
  int gap [MAX_ROWS];
  int num_rows = 0;
  int burst_start = 0;

  int exp_rows [$]; // table rows still owed a commit
  int exp_total = 0;
  int committed = 0;
  int errors = 0;
  logic table_ready = 1'b0;
  logic saw_full = 1'b0;
  logic saw_refill = 1'b0;

  top_level u_top_level (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .instruction(instruction), .iq_valid(iq_valid),
    .iq_ready(iq_ready), .commit(commit), .commit_dest(commit_dest),
    .commit_value(commit_value)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #20 clk_100mhz = ~clk_100mhz;
  end

  function automatic logic [31:0] op_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] opimm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] funct3, input logic [4:0] rd);
    return {imm, rs1, funct3, rd, OPC_OPIMM};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // only the three known opcodes reach the rob
  function automatic logic expects_commit(input logic [31:0] word);
    return word[6:0] == OPC_OP || word[6:0] == OPC_OPIMM || word[6:0] == OPC_LUI;
  endfunction

  task automatic add_row(input string name, input logic [31:0] word, input logic [4:0] dest,
                         input logic [31:0] value);
    row_name[num_rows] = name;
    row_word[num_rows] = word;
    row_dest[num_rows] = dest;
    row_value[num_rows] = value;
    num_rows++;
  endtask

  task automatic build_program();
    // x1 = 5, x2 = -3, x3 = 0x12345000
    add_row("addi_x1", opimm_word(12'd5, 5'd0, 3'b000, 5'd1), 5'd1, 32'd5);
    add_row("addi_neg_x2", opimm_word(12'hffd, 5'd0, 3'b000, 5'd2), 5'd2, 32'hfffffffd);
    add_row("lui_x3", lui_word(20'h12345, 5'd3), 5'd3, 32'h12345000);
    add_row("xor_x4", op_word(7'd0, 5'd2, 5'd1, 3'b100, 5'd4), 5'd4, 32'hfffffff8);
    add_row("or_x5", op_word(7'd0, 5'd3, 5'd1, 3'b110, 5'd5), 5'd5, 32'h12345005);
    add_row("and_x6", op_word(7'd0, 5'd3, 5'd2, 3'b111, 5'd6), 5'd6, 32'h12345000);
    add_row("slt_x7", op_word(7'd0, 5'd1, 5'd2, 3'b010, 5'd7), 5'd7, 32'd1);
    add_row("sltu_x8", op_word(7'd0, 5'd1, 5'd2, 3'b011, 5'd8), 5'd8, 32'd0);
    add_row("sll_x9", op_word(7'd0, 5'd1, 5'd1, 3'b001, 5'd9), 5'd9, 32'h000000a0);
    add_row("srl_x10", op_word(7'd0, 5'd1, 5'd2, 3'b101, 5'd10), 5'd10, 32'h07ffffff);
    add_row("sra_x11", op_word(7'h20, 5'd1, 5'd2, 3'b101, 5'd11), 5'd11, 32'hffffffff);
    add_row("sub_x12", op_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd12), 5'd12, 32'd8);
    // read-after-write chain
    add_row("chain_x13", op_word(7'd0, 5'd1, 5'd1, 3'b000, 5'd13), 5'd13, 32'd10);
    add_row("chain_x14", op_word(7'd0, 5'd1, 5'd13, 3'b000, 5'd14), 5'd14, 32'd15);
    add_row("chain_x15", op_word(7'd0, 5'd14, 5'd14, 3'b000, 5'd15), 5'd15, 32'd30);
    add_row("chain_x16", op_word(7'd0, 5'd13, 5'd15, 3'b000, 5'd16), 5'd16, 32'd40);
    // x0 target still commits its result
    add_row("addi_x0", opimm_word(12'd7, 5'd1, 3'b000, 5'd0), 5'd0, 32'd12);
    add_row("add_x0_src", op_word(7'd0, 5'd1, 5'd0, 3'b000, 5'd17), 5'd17, 32'd5);
    add_row("addi_x0_src", opimm_word(12'd0, 5'd0, 3'b000, 5'd18), 5'd18, 32'd0);
    add_row("nop_a", 32'h0000007f, 5'd0, 32'd0);
    add_row("addi_x19", opimm_word(12'd100, 5'd0, 3'b000, 5'd19), 5'd19, 32'd100);
    add_row("nop_b", 32'h0ff0000f, 5'd0, 32'd0);
    add_row("nop_c", 32'h00000000, 5'd0, 32'd0);
    add_row("addi_x20", opimm_word(12'd1, 5'd19, 3'b000, 5'd20), 5'd20, 32'd101);
    // dependent burst on x21, +3 per step
    burst_start = num_rows;
    add_row("burst_0", opimm_word(12'd3, 5'd0, 3'b000, 5'd21), 5'd21, 32'd3);
    for (int k = 1; k < BURST_LEN; k++) begin
      add_row($sformatf("burst_%0d", k), opimm_word(12'd3, 5'd21, 3'b000, 5'd21), 5'd21,
              32'(3 * (k + 1)));
    end
    // x22 renamed twice before the first retires
    add_row("rewrite_x22_a", opimm_word(12'd11, 5'd0, 3'b000, 5'd22), 5'd22, 32'd11);
    add_row("rewrite_x22_b", opimm_word(12'd22, 5'd0, 3'b000, 5'd22), 5'd22, 32'd22);
    add_row("read_x22", op_word(7'd0, 5'd0, 5'd22, 3'b000, 5'd23), 5'd23, 32'd22);
  endtask

  task automatic check_commit();
    int r;
    assert (exp_rows.size() != 0) else begin
      $display("unexpected commit to x%0d with value %h", commit_dest, commit_value);
      errors++;
    end
    if (exp_rows.size() != 0) begin
      r = exp_rows.pop_front();
      assert (commit_dest == row_dest[r]) else begin
        $display("Fail %s dest expected %0d actual %0d", row_name[r], row_dest[r], commit_dest);
        errors++;
      end
      assert (commit_value == row_value[r]) else begin
        $display("Fail %s value expected %h actual %h", row_name[r], row_value[r],
                 commit_value);
        errors++;
      end
      committed++;
    end
  endtask

  always @(negedge clk_100mhz) begin
    if (rst_n && commit) check_commit();
  end

  // back-pressure seen on the push side
  always @(negedge clk_100mhz) begin
    if (rst_n && !iq_ready) saw_full <= 1'b1;
    if (rst_n && saw_full && iq_ready) saw_refill <= 1'b1;
  end

  initial begin
    wait (table_ready);
    repeat (num_rows * 20 + 50) @(posedge clk_100mhz);
    $display("timeout with %0d of %0d commits missing", exp_total - committed, exp_total);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int seed_draw;
    rst_n = 1'b0;
    iq_valid = 1'b0;
    instruction = '0;
    seed_draw = $urandom(32'h8605);
    build_program();
    for (int i = 0; i < num_rows; i++) begin
      gap[i] = (i < burst_start) ? int'($urandom % 4) : 0; // burst goes back to back
      if (expects_commit(row_word[i])) exp_rows.push_back(i);
    end
    exp_total = exp_rows.size();
    table_ready = 1'b1;

    repeat (3) @(negedge clk_100mhz);
    rst_n = 1'b1;
    assert (!commit && iq_ready) else begin
      $display("outputs not idle right after reset");
      errors++;
    end

    for (int i = 0; i < num_rows; i++) begin
      repeat (gap[i]) @(negedge clk_100mhz);
      while (!iq_ready) @(negedge clk_100mhz);
      instruction = row_word[i];
      iq_valid = 1'b1;
      @(negedge clk_100mhz);
      iq_valid = 1'b0;
    end

    wait (committed == exp_total);
    repeat (10) @(negedge clk_100mhz); // catch stray commits
    assert (saw_full && saw_refill) else begin
      $display("iq_ready did not fall and rise again during the burst");
      errors++;
    end

    $display("errors %0d, commits %0d of %0d", errors, committed, exp_total);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/top_level.sv
`default_nettype none

module top_level import core_pkg::*; #(
  parameter int IQ_SIZE = 4,
  parameter int RS_SIZE = 2,
  parameter int ROB_SIZE = 8
) (
  input wire clk_100mhz,
  input wire rst_n,
  input wire [31:0] instruction,
  input wire iq_valid,
  output logic iq_ready,
  output logic commit,
  output logic [4:0] commit_dest,
  output logic [31:0] commit_value
);

  localparam int TAG_W = $clog2(ROB_SIZE);

  // front end
  inst_word_u head_word;
  logic inst_available, pop, issue;
  inst_type_e inst_type;
  alu_func_e alu_func;
  logic [4:0] rs1, rs2, rd;

  // operand lookup
  logic [31:0] rd1, rd2, val1, val2, op1, op2;
  logic [TAG_W-1:0] tag1, tag2, q1, q2;
  logic busy1, busy2, done1, done2, wait1, wait2;

  logic rob_ready, rs_free;
  logic [TAG_W-1:0] alloc_idx, commit_idx;

  // dispatch and data bus
  logic disp_valid, cdb_valid;
  alu_func_e disp_func;
  logic [31:0] disp_a, disp_b, cdb_value;
  logic [TAG_W-1:0] disp_idx, cdb_idx;

  instruction_queue #(.IQ_SIZE(IQ_SIZE)) u_instruction_queue (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .push(iq_valid), .instruction(instruction),
    .pop(pop), .inst_available(inst_available), .head_word(head_word), .ready(iq_ready)
  );

  decode_issue #(.ROB_SIZE(ROB_SIZE)) u_decode_issue (
    .inst_available(inst_available), .head_word(head_word), .rob_ready(rob_ready),
    .rs_free(rs_free), .rd1(rd1), .rd2(rd2), .busy1(busy1), .busy2(busy2),
    .tag1(tag1), .tag2(tag2), .done1(done1), .done2(done2), .val1(val1), .val2(val2),
    .cdb_valid(cdb_valid), .cdb_idx(cdb_idx), .cdb_value(cdb_value),
    .rs1(rs1), .rs2(rs2), .rd(rd), .alu_func(alu_func), .inst_type(inst_type),
    .issue(issue), .pop(pop), .op1(op1), .op2(op2), .q1(q1), .q2(q2),
    .wait1(wait1), .wait2(wait2)
  );

  register_file #(.ROB_SIZE(ROB_SIZE)) u_register_file (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .issue(issue), .rd(rd),
    .alloc_idx(alloc_idx), .commit(commit), .commit_dest(commit_dest),
    .commit_idx(commit_idx), .commit_value(commit_value), .rd1(rd1), .rd2(rd2),
    .tag1(tag1), .tag2(tag2), .busy1(busy1), .busy2(busy2)
  );

  reservation_station #(.RS_SIZE(RS_SIZE), .ROB_SIZE(ROB_SIZE)) u_reservation_station (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .issue(issue), .alu_func(alu_func),
    .op1(op1), .op2(op2), .q1(q1), .q2(q2), .wait1(wait1), .wait2(wait2),
    .alloc_idx(alloc_idx), .cdb_valid(cdb_valid), .cdb_idx(cdb_idx), .cdb_value(cdb_value),
    .rs_free(rs_free), .disp_valid(disp_valid), .disp_func(disp_func),
    .disp_a(disp_a), .disp_b(disp_b), .disp_idx(disp_idx)
  );

  alu #(.ROB_SIZE(ROB_SIZE)) u_alu (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .disp_valid(disp_valid), .disp_func(disp_func),
    .disp_a(disp_a), .disp_b(disp_b), .disp_idx(disp_idx),
    .cdb_valid(cdb_valid), .cdb_idx(cdb_idx), .cdb_value(cdb_value)
  );

  rob #(.ROB_SIZE(ROB_SIZE)) u_rob (
    .clk_100mhz(clk_100mhz), .rst_n(rst_n), .issue(issue), .inst_type(inst_type), .rd(rd),
    .cdb_valid(cdb_valid), .cdb_idx(cdb_idx), .cdb_value(cdb_value),
    .tag1(tag1), .tag2(tag2), .alloc_idx(alloc_idx), .rob_ready(rob_ready),
    .done1(done1), .done2(done2), .val1(val1), .val2(val2), .commit(commit),
    .commit_dest(commit_dest), .commit_value(commit_value), .commit_idx(commit_idx)
  );

endmodule

`default_nettype wire

// File: verilog/rob.sv
`default_nettype none

module rob import core_pkg::*; #(
  parameter int ROB_SIZE = 8
) (
  input wire clk_100mhz,
  input wire rst_n,
  input wire issue,
  input wire inst_type_e inst_type,
  input wire [4:0] rd,
  input wire cdb_valid,
  input wire [$clog2(ROB_SIZE)-1:0] cdb_idx,
  input wire [31:0] cdb_value,
  input wire [$clog2(ROB_SIZE)-1:0] tag1,
  input wire [$clog2(ROB_SIZE)-1:0] tag2,
  output logic [$clog2(ROB_SIZE)-1:0] alloc_idx,
  output logic rob_ready,
  output logic done1,
  output logic done2,
  output logic [31:0] val1,
  output logic [31:0] val2,
  output logic commit,
  output logic [4:0] commit_dest,
  output logic [31:0] commit_value,
  output logic [$clog2(ROB_SIZE)-1:0] commit_idx
);

  localparam int TAG_W = $clog2(ROB_SIZE);
  localparam int CNT_W = $clog2(ROB_SIZE + 1);

  logic [TAG_W-1:0] head, tail;
  logic [CNT_W-1:0] count;
  logic [ROB_SIZE-1:0] done;
  logic [4:0] dest [ROB_SIZE];
  logic [31:0] value [ROB_SIZE];

  assign alloc_idx = tail;
  assign rob_ready = count != CNT_W'(ROB_SIZE);

  // operand lookups for entries still in flight
  assign done1 = done[tag1];
  assign done2 = done[tag2];
  assign val1 = value[tag1];
  assign val2 = value[tag2];

  // head retires as soon as it is written back
  assign commit = count != '0 && done[head];
  assign commit_idx = head;
  assign commit_dest = dest[head];
  assign commit_value = value[head];

  always_ff @(posedge clk_100mhz) begin
    if (issue) dest[tail] <= (inst_type == NOP) ? 5'd0 : rd;
    if (cdb_valid) value[cdb_idx] <= cdb_value;
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      done <= '0;
    end else begin
      if (issue) begin
        done[tail] <= 1'b0;
        tail <= tail + 1'b1; // power of two wrap
      end
      if (cdb_valid) done[cdb_idx] <= 1'b1;
      if (commit) head <= head + 1'b1;
      count <= count + CNT_W'(issue) - CNT_W'(commit);
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none

module alu import core_pkg::*; #(
  parameter int ROB_SIZE = 8
) (
  input wire clk_100mhz,
  input wire rst_n,
  input wire disp_valid,
  input wire alu_func_e disp_func,
  input wire [31:0] disp_a,
  input wire [31:0] disp_b,
  input wire [$clog2(ROB_SIZE)-1:0] disp_idx,
  output logic cdb_valid,
  output logic [$clog2(ROB_SIZE)-1:0] cdb_idx,
  output logic [31:0] cdb_value
);

  logic [31:0] result;

  always_comb begin
    case (disp_func)
      SUB:  result = disp_a - disp_b;
      AND:  result = disp_a & disp_b;
      OR:   result = disp_a | disp_b;
      XOR:  result = disp_a ^ disp_b;
      SLT:  result = {31'd0, $signed(disp_a) < $signed(disp_b)};
      SLTU: result = {31'd0, disp_a < disp_b};
      SLL:  result = disp_a << disp_b[4:0];
      SRL:  result = disp_a >> disp_b[4:0];
      SRA:  result = $signed(disp_a) >>> disp_b[4:0];
      default: result = disp_a + disp_b;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) cdb_valid <= 1'b0;
    else cdb_valid <= disp_valid; // one pulse per dispatch
  end

  always_ff @(posedge clk_100mhz) begin
    cdb_idx <= disp_idx;
    cdb_value <= result;
  end

endmodule

`default_nettype wire

// File: verilog/reservation_station.sv
`default_nettype none

module reservation_station import core_pkg::*; #(
  parameter int RS_SIZE = 2,
  parameter int ROB_SIZE = 8
) (
  input wire clk_100mhz,
  input wire rst_n,
  input wire issue,
  input wire alu_func_e alu_func,
  input wire [31:0] op1,
  input wire [31:0] op2,
  input wire [$clog2(ROB_SIZE)-1:0] q1,
  input wire [$clog2(ROB_SIZE)-1:0] q2,
  input wire wait1,
  input wire wait2,
  input wire [$clog2(ROB_SIZE)-1:0] alloc_idx,
  input wire cdb_valid,
  input wire [$clog2(ROB_SIZE)-1:0] cdb_idx,
  input wire [31:0] cdb_value,
  output logic rs_free,
  output logic disp_valid,
  output alu_func_e disp_func,
  output logic [31:0] disp_a,
  output logic [31:0] disp_b,
  output logic [$clog2(ROB_SIZE)-1:0] disp_idx
);

  localparam int TAG_W = $clog2(ROB_SIZE);
  localparam int SEL_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;
  localparam int AGE_W = $clog2(RS_SIZE) + 1;

  logic [RS_SIZE-1:0] valid, wait_a, wait_b;
  alu_func_e func [RS_SIZE];
  logic [31:0] val_a [RS_SIZE];
  logic [31:0] val_b [RS_SIZE];
  logic [TAG_W-1:0] tag_a [RS_SIZE];
  logic [TAG_W-1:0] tag_b [RS_SIZE];
  logic [TAG_W-1:0] rob_idx [RS_SIZE];
  logic [AGE_W-1:0] age [RS_SIZE];
  logic [SEL_W-1:0] free_sel, disp_sel;

  assign rs_free = !(&valid);

  always_comb begin
    free_sel = '0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!valid[i]) free_sel = SEL_W'(i); // lowest free slot
    end
  end

  // oldest entry with both operands present
  always_comb begin
    disp_valid = 1'b0;
    disp_sel = '0;
    for (int i = 0; i < RS_SIZE; i++) begin
      if (valid[i] && !wait_a[i] && !wait_b[i] && (!disp_valid || age[i] > age[disp_sel])) begin
        disp_valid = 1'b1;
        disp_sel = SEL_W'(i);
      end
    end
  end

  assign disp_func = func[disp_sel];
  assign disp_a = val_a[disp_sel];
  assign disp_b = val_b[disp_sel];
  assign disp_idx = rob_idx[disp_sel];

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      valid <= '0;
    end else begin
      if (disp_valid) valid[disp_sel] <= 1'b0;
      if (issue) valid[free_sel] <= 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      if (cdb_valid && wait_a[i] && tag_a[i] == cdb_idx) begin
        val_a[i] <= cdb_value;
        wait_a[i] <= 1'b0;
      end
      if (cdb_valid && wait_b[i] && tag_b[i] == cdb_idx) begin
        val_b[i] <= cdb_value;
        wait_b[i] <= 1'b0;
      end
      if (issue && valid[i] && age[i] != {AGE_W{1'b1}}) age[i] <= age[i] + 1'b1; // saturates
    end
    if (issue) begin
      func[free_sel] <= alu_func;
      val_a[free_sel] <= op1;
      val_b[free_sel] <= op2;
      tag_a[free_sel] <= q1;
      tag_b[free_sel] <= q2;
      wait_a[free_sel] <= wait1;
      wait_b[free_sel] <= wait2;
      rob_idx[free_sel] <= alloc_idx;
      age[free_sel] <= '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`default_nettype none

module register_file #(
  parameter int ROB_SIZE = 8
) (
  input wire clk_100mhz,
  input wire rst_n,
  input wire [4:0] rs1,
  input wire [4:0] rs2,
  input wire issue,
  input wire [4:0] rd,
  input wire [$clog2(ROB_SIZE)-1:0] alloc_idx,
  input wire commit,
  input wire [4:0] commit_dest,
  input wire [$clog2(ROB_SIZE)-1:0] commit_idx,
  input wire [31:0] commit_value,
  output logic [31:0] rd1,
  output logic [31:0] rd2,
  output logic [$clog2(ROB_SIZE)-1:0] tag1,
  output logic [$clog2(ROB_SIZE)-1:0] tag2,
  output logic busy1,
  output logic busy2
);

  localparam int TAG_W = $clog2(ROB_SIZE);

  logic [31:0] regs [32];
  logic [TAG_W-1:0] tags [32];
  logic [31:0] busy;
  logic commit_wr, rename;
  logic hit1, hit2;

  assign commit_wr = commit && commit_dest != 5'd0; // x0 stays zero
  assign rename = issue && rd != 5'd0;

  always_ff @(posedge clk_100mhz) begin
    if (commit_wr) regs[commit_dest] <= commit_value;
    if (rename) tags[rd] <= alloc_idx;
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (commit_wr && tags[commit_dest] == commit_idx) busy[commit_dest] <= 1'b0;
      if (rename) busy[rd] <= 1'b1; // new producer beats the clear
    end
  end

  // forward the retiring value
  assign hit1 = commit_wr && commit_dest == rs1;
  assign hit2 = commit_wr && commit_dest == rs2;

  assign rd1 = (rs1 == 5'd0) ? 32'd0 : (hit1 ? commit_value : regs[rs1]);
  assign rd2 = (rs2 == 5'd0) ? 32'd0 : (hit2 ? commit_value : regs[rs2]);
  assign tag1 = tags[rs1];
  assign tag2 = tags[rs2];
  assign busy1 = busy[rs1] && !(hit1 && tags[rs1] == commit_idx);
  assign busy2 = busy[rs2] && !(hit2 && tags[rs2] == commit_idx);

endmodule

`default_nettype wire

// File: verilog/decode_issue.sv
`default_nettype none

module decode_issue import core_pkg::*; #(
  parameter int ROB_SIZE = 8
) (
  input wire inst_available,
  input wire inst_word_u head_word,
  input wire rob_ready,
  input wire rs_free,
  input wire [31:0] rd1,
  input wire [31:0] rd2,
  input wire busy1,
  input wire busy2,
  input wire [$clog2(ROB_SIZE)-1:0] tag1,
  input wire [$clog2(ROB_SIZE)-1:0] tag2,
  input wire done1,
  input wire done2,
  input wire [31:0] val1,
  input wire [31:0] val2,
  input wire cdb_valid,
  input wire [$clog2(ROB_SIZE)-1:0] cdb_idx,
  input wire [31:0] cdb_value,
  output logic [4:0] rs1,
  output logic [4:0] rs2,
  output logic [4:0] rd,
  output alu_func_e alu_func,
  output inst_type_e inst_type,
  output logic issue,
  output logic pop,
  output logic [31:0] op1,
  output logic [31:0] op2,
  output logic [$clog2(ROB_SIZE)-1:0] q1,
  output logic [$clog2(ROB_SIZE)-1:0] q2,
  output logic wait1,
  output logic wait2
);

  localparam int TAG_W = $clog2(ROB_SIZE);

  logic [31:0] imm_i, imm_u;
  logic [32:0] src1, src2; // {wait, value}

  // register file, then finished rob entry, then the bus, else wait on tag
  function automatic logic [32:0] resolve(input logic busy, input logic [31:0] rf_val,
                                          input logic [TAG_W-1:0] tag, input logic done,
                                          input logic [31:0] rob_val, input logic bus_valid,
                                          input logic [TAG_W-1:0] bus_idx,
                                          input logic [31:0] bus_val);
    if (!busy) return {1'b0, rf_val};
    if (done) return {1'b0, rob_val};
    if (bus_valid && bus_idx == tag) return {1'b0, bus_val};
    return {1'b1, 32'd0};
  endfunction

  assign rs1 = head_word.r.rs1;
  assign rs2 = head_word.r.rs2;
  assign rd = head_word.r.rd;
  assign imm_i = {{20{head_word.i.imm12[11]}}, head_word.i.imm12};
  assign imm_u = {head_word.u.imm20, 12'd0};

  always_comb begin
    case (head_word.r.opcode)
      OPC_OP:    inst_type = OP;
      OPC_OPIMM: inst_type = OPIMM;
      OPC_LUI:   inst_type = LUI;
      default:   inst_type = NOP;
    endcase
  end

  always_comb begin
    alu_func = ADD; // lui adds zero
    if (inst_type == OP || inst_type == OPIMM) begin
      case (head_word.r.funct3)
        3'b000: if (inst_type == OP && head_word.r.funct7[5]) alu_func = SUB;
        3'b001: alu_func = SLL;
        3'b010: alu_func = SLT;
        3'b011: alu_func = SLTU;
        3'b100: alu_func = XOR;
        3'b101: if (head_word.r.funct7[5]) alu_func = SRA; else alu_func = SRL;
        3'b110: alu_func = OR;
        default: alu_func = AND;
      endcase
    end
  end

  assign src1 = resolve(busy1, rd1, tag1, done1, val1, cdb_valid, cdb_idx, cdb_value);
  assign src2 = resolve(busy2, rd2, tag2, done2, val2, cdb_valid, cdb_idx, cdb_value);

  always_comb begin
    op1 = src1[31:0];
    wait1 = src1[32];
    q1 = tag1;
    op2 = src2[31:0];
    wait2 = src2[32];
    q2 = tag2;
    if (inst_type == OPIMM) begin
      op2 = imm_i;
      wait2 = 1'b0;
    end else if (inst_type == LUI) begin
      op1 = '0;
      wait1 = 1'b0;
      op2 = imm_u;
      wait2 = 1'b0;
    end
  end

  assign issue = inst_available && rob_ready && rs_free && inst_type != NOP;
  assign pop = issue || (inst_available && inst_type == NOP); // nops just drain

endmodule

`default_nettype wire

// File: verilog/instruction_queue.sv
`default_nettype none

module instruction_queue import core_pkg::*; #(
  parameter int IQ_SIZE = 4
) (
  input wire clk_100mhz,
  input wire rst_n,
  input wire push,
  input wire [31:0] instruction,
  input wire pop,
  output logic inst_available,
  output inst_word_u head_word,
  output logic ready
);

  localparam int PTR_W = (IQ_SIZE > 1) ? $clog2(IQ_SIZE) : 1;
  localparam int CNT_W = $clog2(IQ_SIZE + 1);

  inst_word_u mem [IQ_SIZE];
  logic [PTR_W-1:0] rd_ptr, wr_ptr;
  logic [CNT_W-1:0] count;
  logic do_push, do_pop;

  assign ready = count != CNT_W'(IQ_SIZE);
  assign inst_available = count != '0;
  assign head_word = mem[rd_ptr];

  assign do_push = push && ready; // dropped when full
  assign do_pop = pop && inst_available;

  always_ff @(posedge clk_100mhz) begin
    if (do_push) mem[wr_ptr] <= instruction;
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(IQ_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(IQ_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

  // instruction class seen by issue and the rob
  typedef enum logic [1:0] {
    OP,
    OPIMM,
    LUI,
    NOP
  } inst_type_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLTU,
    SLL,
    SRL,
    SRA
  } alu_func_e;

  // major opcodes, anything else is a nop
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } inst_word_u;

endpackage

`default_nettype wire
